//--- src.f
logic/align_pkg.sv
logic/reg_cmd_if.sv
logic/wb_reg_port.sv
logic/align_ctrl_bank.sv
logic/biterr_meter.sv
logic/surf_align_regs.sv
tests/surf_align_checker.sv
tests/tb_surf_align.sv

//--- tests/tb_surf_align.sv
`timescale 1ns/1ns

module tb_surf_align;

    logic                   sysclk_i;
    logic                   wb_rst_i;
    logic                   wb_cyc_i;
    logic                   wb_stb_i;
    logic                   wb_we_i;
    align_pkg::reg_addr_t   wb_adr_i;
    align_pkg::byte_sel_t   wb_sel_i;
    align_pkg::wb_data_t    wb_dat_i;
    align_pkg::wb_data_t    wb_dat_o;
    logic                   wb_ack_o;
    logic                   surf_live_i;
    logic                   surf_autotrain_en_i;
    logic                   idelay_cout_load_o;
    logic                   idelay_dout_load_o;
    align_pkg::idelay_tap_t idelay_value_o;
    align_pkg::idelay_tap_t idelay_cout_current_i;
    align_pkg::idelay_tap_t idelay_dout_current_i;
    logic                   iserdes_rst_o;
    logic                   iserdes_cout_bitslip_o;
    logic                   iserdes_dout_bitslip_o;
    logic                   oserdes_rst_o;
    align_pkg::cout_data_t  cout_data_i;
    logic                   cout_biterr_i;
    logic                   cout_enable_o;
    logic                   cout_capture_o;
    align_pkg::dout_data_t  dout_data_i;
    logic                   dout_biterr_i;
    logic                   dout_enable_o;
    logic                   dout_capture_o;
    logic                   dout_capture_phase_o;
    logic                   cin_train_o;
    logic                   mask_o;

    // reference model of the control bits and the merged command word
    logic                   m_iser;
    logic                   m_oser;
    logic                   m_phase;
    logic                   m_cen;
    logic                   m_den;
    logic                   m_train;
    align_pkg::wb_data_t    m_word;

    integer                 seed;
    int                     errors;
    int                     cnt;
    int                     n_int;
    align_pkg::reg_addr_t   adr;
    align_pkg::byte_sel_t   sel;
    align_pkg::wb_data_t    dat;
    align_pkg::wb_data_t    rdata;
    align_pkg::wb_data_t    exp_rd;
    logic                   we;
    logic [5:0]             strb;
    logic [5:0]             exp_strb;
    align_pkg::idelay_tap_t ival;

    surf_align_regs DUT (.*);
    bind surf_align_regs surf_align_checker u_checker (.*);

    initial begin
        sysclk_i = 1'b0;
        forever #2 sysclk_i = ~sysclk_i;
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[FAIL] t=%0t ns %s: got %h, expected %h", $time, what, got, exp);
    endtask

    // one bus access, driven on the falling edge, sampled in the ack cycle
    task automatic bus_access(input logic w, input align_pkg::reg_addr_t a,
                              input align_pkg::byte_sel_t s, input align_pkg::wb_data_t d,
                              output align_pkg::wb_data_t rd, output logic [5:0] st,
                              output align_pkg::idelay_tap_t iv);
        int n;
        @(negedge sysclk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = w;
        wb_adr_i = a;
        wb_sel_i = s;
        wb_dat_i = d;
        @(negedge sysclk_i);
        n = 1;
        while (!wb_ack_o && n < 8) begin
            @(negedge sysclk_i);
            n++;
        end
        if (!wb_ack_o) begin
            errors++;
            $display("timeout: DUT never acked the access to address %h", a);
        end
        rd = wb_dat_o;
        st = {idelay_cout_load_o, idelay_dout_load_o, iserdes_cout_bitslip_o,
              iserdes_dout_bitslip_o, cout_capture_o, dout_capture_o};
        iv = idelay_value_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        // every access merges its selected bytes into the command word
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                m_word[8*i +: 8] = d[8*i +: 8];
            end
        end
    endtask

    // expected readback of a control register
    function automatic align_pkg::wb_data_t exp_ctrl_word(input logic is_dout);
        align_pkg::wb_data_t w;
        logic en;
        w = '0;
        en = is_dout ? m_den : m_cen;
        w[align_pkg::CTL_ISERDES_RST]   = m_iser;
        w[align_pkg::CTL_OSERDES_RST]   = m_oser;
        w[align_pkg::CTL_CIN_TRAIN]     = m_train;
        w[align_pkg::CTL_ENABLE]        = en;
        w[align_pkg::CTL_ENABLE_STATUS] = en;
        if (is_dout) begin
            w[align_pkg::CTL_CAPTURE_PHASE] = m_phase;
        end
        return w;
    endfunction

    task automatic check_ctrl_outputs();
        if (iserdes_rst_o !== m_iser) report_mismatch("iserdes_rst_o", iserdes_rst_o, m_iser);
        if (oserdes_rst_o !== m_oser) report_mismatch("oserdes_rst_o", oserdes_rst_o, m_oser);
        if (dout_capture_phase_o !== m_phase)
            report_mismatch("dout_capture_phase_o", dout_capture_phase_o, m_phase);
        if (cout_enable_o !== m_cen) report_mismatch("cout_enable_o", cout_enable_o, m_cen);
        if (dout_enable_o !== m_den) report_mismatch("dout_enable_o", dout_enable_o, m_den);
        if (cin_train_o !== m_train) report_mismatch("cin_train_o", cin_train_o, m_train);
        if (mask_o !== !m_den) report_mismatch("mask_o", mask_o, !m_den);
    endtask

    initial begin
        seed = 32'h7c06;
        errors = 0;
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        surf_live_i = 1'b1;
        surf_autotrain_en_i = 1'b0;
        idelay_cout_current_i = '0;
        idelay_dout_current_i = '0;
        cout_data_i = '0;
        dout_data_i = '0;
        cout_biterr_i = 1'b0;
        dout_biterr_i = 1'b0;
        {m_iser, m_oser, m_phase, m_cen, m_den, m_train} = 6'b110000;
        m_word = '0;
        repeat (10) @(negedge sysclk_i);
        wb_rst_i = 1'b0;

        ////////////////////
        // reset state
        ////////////////////
        check_ctrl_outputs();
        bus_access(1'b0, align_pkg::COUT_CONTROL_REG, 4'hf, '0, rdata, strb, ival);
        if (rdata !== exp_ctrl_word(1'b0))
            report_mismatch("cout ctrl", rdata, exp_ctrl_word(1'b0));
        bus_access(1'b0, align_pkg::DOUT_CONTROL_REG, 4'hf, '0, rdata, strb, ival);
        if (rdata !== exp_ctrl_word(1'b1))
            report_mismatch("dout ctrl", rdata, exp_ctrl_word(1'b1));

        ////////////////////
        // random control writes
        ////////////////////
        for (int k = 0; k < 40; k++) begin
            adr = ($random(seed) & 1) ? align_pkg::DOUT_CONTROL_REG : align_pkg::COUT_CONTROL_REG;
            sel = $random(seed);
            dat = $random(seed);
            bus_access(1'b1, adr, sel, dat, rdata, strb, ival);
            if (strb !== 6'b0) report_mismatch("strobes on ctrl write", strb, 6'b0);
            if (sel[0]) begin
                m_iser  = dat[align_pkg::CTL_ISERDES_RST];
                m_oser  = dat[align_pkg::CTL_OSERDES_RST];
                m_phase = dat[align_pkg::CTL_CAPTURE_PHASE];
            end
            if (sel[1]) begin
                m_train = dat[align_pkg::CTL_CIN_TRAIN];
                if (adr == align_pkg::DOUT_CONTROL_REG) m_den = dat[align_pkg::CTL_ENABLE];
                else m_cen = dat[align_pkg::CTL_ENABLE];
            end
            // new state shows one cycle after ack
            @(negedge sysclk_i);
            check_ctrl_outputs();
            bus_access(1'b0, adr, $random(seed), $random(seed), rdata, strb, ival);
            exp_rd = exp_ctrl_word(adr == align_pkg::DOUT_CONTROL_REG);
            if (rdata !== exp_rd) report_mismatch("ctrl readback", rdata, exp_rd);
        end

        ////////////////////
        // idelay and data accesses
        ////////////////////
        for (int k = 0; k < 60; k++) begin
            case ({$random(seed)} % 5)
                0: adr = align_pkg::COUT_IDELAY_REG;
                1: adr = align_pkg::DOUT_IDELAY_REG;
                2: adr = align_pkg::COUT_DATA_REG;
                3: adr = align_pkg::DOUT_DATA_REG;
                default: adr = 6'h28;
            endcase
            we = $random(seed);
            idelay_cout_current_i = $random(seed);
            idelay_dout_current_i = $random(seed);
            cout_data_i = $random(seed);
            dout_data_i = $random(seed);
            bus_access(we, adr, $random(seed), $random(seed), rdata, strb, ival);
            exp_strb = 6'b0;
            exp_rd = '0;
            case (adr)
                align_pkg::COUT_IDELAY_REG: begin
                    exp_strb = we ? 6'b100000 : 6'b0;
                    exp_rd   = {26'b0, idelay_cout_current_i};
                end
                align_pkg::DOUT_IDELAY_REG: begin
                    exp_strb = we ? 6'b010000 : 6'b0;
                    exp_rd   = {26'b0, idelay_dout_current_i};
                end
                align_pkg::COUT_DATA_REG: begin
                    exp_strb = we ? 6'b001000 : 6'b000010;
                    exp_rd   = cout_data_i;
                end
                align_pkg::DOUT_DATA_REG: begin
                    exp_strb = we ? 6'b000100 : 6'b000001;
                    exp_rd   = {24'b0, dout_data_i};
                end
                default: ;
            endcase
            if (strb !== exp_strb) report_mismatch("strobes", strb, exp_strb);
            if (ival !== m_word[5:0]) report_mismatch("idelay_value_o", ival, m_word[5:0]);
            if (!we && rdata !== exp_rd) report_mismatch("read data", rdata, exp_rd);
        end

        ////////////////////
        // error meter
        ////////////////////
        n_int = 4 + ({$random(seed)} % 12);
        cout_biterr_i = 1'b1;
        dout_biterr_i = 1'b0;
        bus_access(1'b1, align_pkg::COUT_BIT_ERROR_COUNT_REG, 4'hf, n_int, rdata, strb, ival);
        repeat (2 * n_int + 4) @(negedge sysclk_i);
        bus_access(1'b0, align_pkg::DOUT_BIT_ERROR_COUNT_REG, 4'hf, '0, rdata, strb, ival);
        if (rdata !== n_int) report_mismatch("cout error count", rdata, n_int);
        // retarget to the quiet source
        bus_access(1'b1, align_pkg::DOUT_BIT_ERROR_COUNT_REG, 4'hf, n_int, rdata, strb, ival);
        repeat (2 * n_int + 4) @(negedge sysclk_i);
        bus_access(1'b0, align_pkg::COUT_BIT_ERROR_COUNT_REG, 4'hf, '0, rdata, strb, ival);
        if (rdata !== 32'd0) report_mismatch("dout error count", rdata, 32'd0);

        ////////////////////
        // autotrain and live loss
        ////////////////////
        // oserdes into reset, training and cout enable off
        bus_access(1'b1, align_pkg::COUT_CONTROL_REG, 4'h3, 32'h14, rdata, strb, ival);
        @(negedge sysclk_i);
        if (cin_train_o !== 1'b0)
            report_mismatch("cin_train_o before autotrain", cin_train_o, 1'b0);
        if (oserdes_rst_o !== 1'b1)
            report_mismatch("oserdes_rst_o before autotrain", oserdes_rst_o, 1'b1);
        surf_autotrain_en_i = 1'b1;
        cnt = 0;
        while (!cin_train_o && cnt < 2) begin
            @(negedge sysclk_i);
            cnt++;
        end
        if (!cin_train_o) report_mismatch("cin_train_o after autotrain", cin_train_o, 1'b1);
        while (oserdes_rst_o && cnt < align_pkg::AUTOTRAIN_DELAY + 2) begin
            @(negedge sysclk_i);
            cnt++;
        end
        if (oserdes_rst_o) report_mismatch("oserdes_rst_o after autotrain", oserdes_rst_o, 1'b0);
        surf_live_i = 1'b0;
        cnt = 0;
        while (!oserdes_rst_o && cnt < 3) begin
            @(negedge sysclk_i);
            cnt++;
        end
        if (!oserdes_rst_o) report_mismatch("oserdes_rst_o after live loss", oserdes_rst_o, 1'b1);

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/surf_align_checker.sv
`timescale 1ns/1ns

module surf_align_checker (
    input logic sysclk_i,
    input logic wb_rst_i,
    input logic wb_ack_o,
    input logic mask_o,
    // channel control outputs
    input logic iserdes_rst_o,
    input logic oserdes_rst_o,
    input logic cout_enable_o,
    input logic dout_enable_o,
    input logic dout_capture_phase_o,
    input logic cin_train_o,
    // one-cycle strobes
    input logic idelay_cout_load_o,
    input logic idelay_dout_load_o,
    input logic iserdes_cout_bitslip_o,
    input logic iserdes_dout_bitslip_o,
    input logic cout_capture_o,
    input logic dout_capture_o
);

    logic any_strobe;

    assign any_strobe = idelay_cout_load_o | idelay_dout_load_o | iserdes_cout_bitslip_o |
                        iserdes_dout_bitslip_o | cout_capture_o | dout_capture_o;

    ////////////////////
    // bus side
    ////////////////////

    // ack is a single cycle pulse
    ack_single: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wb_ack_o held for two cycles");

    // strobes only in the ack cycle
    strobe_in_ack: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        any_strobe |-> wb_ack_o)
        else $error("strobe outside the ack cycle");

    ////////////////////
    // control side
    ////////////////////

    mask_inverse: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        mask_o == !dout_enable_o)
        else $error("mask_o is not the inverse of dout_enable_o");

    // first cycle out of reset still shows the reset state
    reset_values: assert property (@(posedge sysclk_i) $fell(wb_rst_i) |->
        (iserdes_rst_o && oserdes_rst_o && !cout_enable_o && !dout_enable_o &&
         !dout_capture_phase_o && !cin_train_o && mask_o && !any_strobe && !wb_ack_o))
        else $error("control outputs left their reset values right after reset");

endmodule

//--- logic/surf_align_regs.sv
`timescale 1ns/1ns

module surf_align_regs (
    input  logic                   sysclk_i,
    input  logic                   wb_rst_i,
    // wishbone slave, err and rty not provided
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  align_pkg::reg_addr_t   wb_adr_i,
    input  align_pkg::byte_sel_t   wb_sel_i,
    input  align_pkg::wb_data_t    wb_dat_i,
    output align_pkg::wb_data_t    wb_dat_o,
    output logic                   wb_ack_o,
    // live detector and sequencer
    input  logic                   surf_live_i,
    input  logic                   surf_autotrain_en_i,
    // idelays
    output logic                   idelay_cout_load_o,
    output logic                   idelay_dout_load_o,
    output align_pkg::idelay_tap_t idelay_value_o,
    input  align_pkg::idelay_tap_t idelay_cout_current_i,
    input  align_pkg::idelay_tap_t idelay_dout_current_i,
    // serdes
    output logic                   iserdes_rst_o,
    output logic                   iserdes_cout_bitslip_o,
    output logic                   iserdes_dout_bitslip_o,
    output logic                   oserdes_rst_o,
    // cout channel
    input  align_pkg::cout_data_t  cout_data_i,
    input  logic                   cout_biterr_i,
    output logic                   cout_enable_o,
    output logic                   cout_capture_o,
    // dout channel
    input  align_pkg::dout_data_t  dout_data_i,
    input  logic                   dout_biterr_i,
    output logic                   dout_enable_o,
    output logic                   dout_capture_o,
    output logic                   dout_capture_phase_o,
    // training and event mask
    output logic                   cin_train_o,
    output logic                   mask_o
);

    reg_cmd_if cmd ();

    align_pkg::wb_data_t   cout_ctrl_word;
    align_pkg::wb_data_t   dout_ctrl_word;
    align_pkg::err_count_t err_count;

    wb_reg_port u_port (
        .sysclk_i(sysclk_i), .wb_rst_i(wb_rst_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .cmd(cmd.issuer),
        .cout_ctrl_word_i(cout_ctrl_word), .dout_ctrl_word_i(dout_ctrl_word),
        .err_count_i(err_count),
        .idelay_cout_current_i(idelay_cout_current_i),
        .idelay_dout_current_i(idelay_dout_current_i),
        .cout_data_i(cout_data_i), .dout_data_i(dout_data_i)
    );

    align_ctrl_bank u_bank (
        .sysclk_i(sysclk_i), .wb_rst_i(wb_rst_i),
        .cmd(cmd.bank),
        .surf_live_i(surf_live_i), .surf_autotrain_en_i(surf_autotrain_en_i),
        .idelay_cout_load_o(idelay_cout_load_o), .idelay_dout_load_o(idelay_dout_load_o),
        .idelay_value_o(idelay_value_o),
        .iserdes_rst_o(iserdes_rst_o),
        .iserdes_cout_bitslip_o(iserdes_cout_bitslip_o),
        .iserdes_dout_bitslip_o(iserdes_dout_bitslip_o),
        .oserdes_rst_o(oserdes_rst_o),
        .cout_enable_o(cout_enable_o), .cout_capture_o(cout_capture_o),
        .dout_enable_o(dout_enable_o), .dout_capture_o(dout_capture_o),
        .dout_capture_phase_o(dout_capture_phase_o),
        .cin_train_o(cin_train_o), .mask_o(mask_o),
        .cout_ctrl_word_o(cout_ctrl_word), .dout_ctrl_word_o(dout_ctrl_word)
    );

    biterr_meter u_meter (
        .sysclk_i(sysclk_i), .wb_rst_i(wb_rst_i),
        .cmd(cmd.meter),
        .cout_biterr_i(cout_biterr_i), .dout_biterr_i(dout_biterr_i),
        .err_count_o(err_count)
    );

endmodule

//--- logic/biterr_meter.sv
`timescale 1ns/1ns

module biterr_meter (
    input  logic                  sysclk_i,
    input  logic                  wb_rst_i,
    reg_cmd_if.meter              cmd,
    input  logic                  cout_biterr_i,
    input  logic                  dout_biterr_i,
    output align_pkg::err_count_t err_count_o
);

    logic                  load;
    logic                  use_dout;
    logic                  err_q;
    logic                  win_end;
    align_pkg::interval_t  interval;
    align_pkg::interval_t  win_cnt;
    align_pkg::err_count_t err_acc;
    align_pkg::err_count_t err_sum;

    // interval write to either channel retargets the one meter
    assign load = cmd.cmd_valid && cmd.cmd_we &&
                  (cmd.cmd_adr == align_pkg::COUT_BIT_ERROR_COUNT_REG ||
                   cmd.cmd_adr == align_pkg::DOUT_BIT_ERROR_COUNT_REG);

    // running total including this cycle
    assign err_sum = err_acc + align_pkg::err_count_t'(err_q);
    assign win_end = (win_cnt == interval - align_pkg::interval_t'(1));

    // source mux, one register stage
    always_ff @(posedge sysclk_i) begin
        err_q <= use_dout ? dout_biterr_i : cout_biterr_i;
    end

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            use_dout    <= 1'b0;
            interval    <= '0;
            win_cnt     <= '0;
            err_acc     <= '0;
            err_count_o <= '0;
        end else if (load) begin
            // low 24 bits are the window length
            interval <= align_pkg::interval_t'(cmd.cmd_dat);
            use_dout <= (cmd.cmd_adr == align_pkg::DOUT_BIT_ERROR_COUNT_REG);
            win_cnt  <= '0;
            err_acc  <= '0;
        end else if (interval != '0) begin
            if (win_end) begin
                // publish and start the next window
                err_count_o <= err_sum;
                win_cnt     <= '0;
                err_acc     <= '0;
            end else begin
                win_cnt <= win_cnt + align_pkg::interval_t'(1);
                err_acc <= err_sum;
            end
        end
        // zero interval leaves the last result in place
    end

endmodule

//--- logic/align_ctrl_bank.sv
`timescale 1ns/1ns

module align_ctrl_bank (
    input  logic                   sysclk_i,
    input  logic                   wb_rst_i,
    reg_cmd_if.bank                cmd,
    // automatic sequencing inputs
    input  logic                   surf_live_i,
    input  logic                   surf_autotrain_en_i,
    // idelay load and common value
    output logic                   idelay_cout_load_o,
    output logic                   idelay_dout_load_o,
    output align_pkg::idelay_tap_t idelay_value_o,
    // serdes resets and bitslips
    output logic                   iserdes_rst_o,
    output logic                   iserdes_cout_bitslip_o,
    output logic                   iserdes_dout_bitslip_o,
    output logic                   oserdes_rst_o,
    // channel enables and capture
    output logic                   cout_enable_o,
    output logic                   cout_capture_o,
    output logic                   dout_enable_o,
    output logic                   dout_capture_o,
    output logic                   dout_capture_phase_o,
    output logic                   cin_train_o,
    output logic                   mask_o,
    // readback words
    output align_pkg::wb_data_t    cout_ctrl_word_o,
    output align_pkg::wb_data_t    dout_ctrl_word_o
);

    logic                                  wr;
    logic                                  rd;
    logic                                  cout_ctl_wr;
    logic                                  dout_ctl_wr;
    logic                                  live_q;
    logic                                  live_fall;
    logic [align_pkg::AUTOTRAIN_DELAY-1:0] train_dly;
    align_pkg::wb_data_t                   common_word;

    ////////////////////
    // access decode
    ////////////////////

    assign wr = cmd.cmd_valid && cmd.cmd_we;
    assign rd = cmd.cmd_valid && !cmd.cmd_we;
    assign cout_ctl_wr = wr && (cmd.cmd_adr == align_pkg::COUT_CONTROL_REG);
    assign dout_ctl_wr = wr && (cmd.cmd_adr == align_pkg::DOUT_CONTROL_REG);

    // strobes line up with the ack cycle
    assign idelay_cout_load_o     = wr && (cmd.cmd_adr == align_pkg::COUT_IDELAY_REG);
    assign idelay_dout_load_o     = wr && (cmd.cmd_adr == align_pkg::DOUT_IDELAY_REG);
    assign iserdes_cout_bitslip_o = wr && (cmd.cmd_adr == align_pkg::COUT_DATA_REG);
    assign iserdes_dout_bitslip_o = wr && (cmd.cmd_adr == align_pkg::DOUT_DATA_REG);
    assign cout_capture_o         = rd && (cmd.cmd_adr == align_pkg::COUT_DATA_REG);
    assign dout_capture_o         = rd && (cmd.cmd_adr == align_pkg::DOUT_DATA_REG);
    // same tap value goes to both idelays
    assign idelay_value_o = align_pkg::idelay_tap_t'(cmd.cmd_dat);

    // surf dropping out sends cout back into reset
    assign live_fall = live_q && !surf_live_i;

    ////////////////////
    // control state
    ////////////////////

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            // serdes come up held in reset
            iserdes_rst_o        <= 1'b1;
            oserdes_rst_o        <= 1'b1;
            dout_capture_phase_o <= 1'b0;
            cout_enable_o        <= 1'b0;
            dout_enable_o        <= 1'b0;
            cin_train_o          <= 1'b0;
            live_q               <= 1'b0;
            train_dly            <= '0;
        end else begin
            live_q    <= surf_live_i;
            train_dly <= {train_dly[align_pkg::AUTOTRAIN_DELAY-2:0], surf_autotrain_en_i};
            if (cout_ctl_wr || dout_ctl_wr) begin
                // shared bits, either control address reaches them
                if (cmd.cmd_sel[0]) begin
                    iserdes_rst_o        <= cmd.cmd_dat[align_pkg::CTL_ISERDES_RST];
                    oserdes_rst_o        <= cmd.cmd_dat[align_pkg::CTL_OSERDES_RST];
                    dout_capture_phase_o <= cmd.cmd_dat[align_pkg::CTL_CAPTURE_PHASE];
                end
                if (cmd.cmd_sel[1]) begin
                    cin_train_o <= cmd.cmd_dat[align_pkg::CTL_CIN_TRAIN];
                    // enables are per channel
                    if (cout_ctl_wr) begin
                        cout_enable_o <= cmd.cmd_dat[align_pkg::CTL_ENABLE];
                    end
                    if (dout_ctl_wr) begin
                        dout_enable_o <= cmd.cmd_dat[align_pkg::CTL_ENABLE];
                    end
                end
            end else begin
                // live loss wins over the delayed autotrain release
                if (live_fall) begin
                    oserdes_rst_o <= 1'b1;
                end else if (train_dly[align_pkg::AUTOTRAIN_DELAY-1]) begin
                    oserdes_rst_o <= 1'b0;
                end
                if (surf_autotrain_en_i) begin
                    cin_train_o <= 1'b1;
                end
            end
        end
    end

    // events only pass once dout is trusted
    assign mask_o = !dout_enable_o;

    ////////////////////
    // readback words
    ////////////////////

    always_comb begin
        common_word = '0;
        common_word[align_pkg::CTL_ISERDES_RST] = iserdes_rst_o;
        common_word[align_pkg::CTL_OSERDES_RST] = oserdes_rst_o;
        common_word[align_pkg::CTL_CIN_TRAIN]   = cin_train_o;
        // status bit mirrors the enable
        cout_ctrl_word_o = common_word;
        cout_ctrl_word_o[align_pkg::CTL_ENABLE]        = cout_enable_o;
        cout_ctrl_word_o[align_pkg::CTL_ENABLE_STATUS] = cout_enable_o;
        // capture phase only shows up on dout
        dout_ctrl_word_o = common_word;
        dout_ctrl_word_o[align_pkg::CTL_CAPTURE_PHASE] = dout_capture_phase_o;
        dout_ctrl_word_o[align_pkg::CTL_ENABLE]        = dout_enable_o;
        dout_ctrl_word_o[align_pkg::CTL_ENABLE_STATUS] = dout_enable_o;
    end

endmodule

//--- logic/wb_reg_port.sv
`timescale 1ns/1ns

module wb_reg_port (
    input  logic                   sysclk_i,
    input  logic                   wb_rst_i,
    // wishbone slave
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  align_pkg::reg_addr_t   wb_adr_i,
    input  align_pkg::byte_sel_t   wb_sel_i,
    input  align_pkg::wb_data_t    wb_dat_i,
    output align_pkg::wb_data_t    wb_dat_o,
    output logic                   wb_ack_o,
    // accepted access out to the bank and meter
    reg_cmd_if.issuer              cmd,
    // readback sources
    input  align_pkg::wb_data_t    cout_ctrl_word_i,
    input  align_pkg::wb_data_t    dout_ctrl_word_i,
    input  align_pkg::err_count_t  err_count_i,
    input  align_pkg::idelay_tap_t idelay_cout_current_i,
    input  align_pkg::idelay_tap_t idelay_dout_current_i,
    input  align_pkg::cout_data_t  cout_data_i,
    input  align_pkg::dout_data_t  dout_data_i
);

    align_pkg::bus_state_t state;
    align_pkg::wb_data_t   rd_word;
    logic                  accept;

    // a request is only taken from idle, a held strobe waits one cycle
    assign accept = wb_cyc_i && wb_stb_i && (state == align_pkg::IDLE);

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            state <= align_pkg::IDLE;
        end else begin
            case (state)
                align_pkg::IDLE: begin
                    if (accept) begin
                        state <= align_pkg::ACK;
                    end
                end
                default: begin
                    // ack lasts exactly one cycle
                    state <= align_pkg::IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // read data select
    ////////////////////

    // everything narrower than the bus is zero extended
    always_comb begin
        case (wb_adr_i)
            align_pkg::COUT_CONTROL_REG:         rd_word = cout_ctrl_word_i;
            align_pkg::DOUT_CONTROL_REG:         rd_word = dout_ctrl_word_i;
            align_pkg::COUT_IDELAY_REG:
                rd_word = align_pkg::wb_data_t'(idelay_cout_current_i);
            align_pkg::DOUT_IDELAY_REG:
                rd_word = align_pkg::wb_data_t'(idelay_dout_current_i);
            // one shared meter behind both addresses
            align_pkg::COUT_BIT_ERROR_COUNT_REG,
            align_pkg::DOUT_BIT_ERROR_COUNT_REG: rd_word = align_pkg::wb_data_t'(err_count_i);
            align_pkg::COUT_DATA_REG:            rd_word = align_pkg::wb_data_t'(cout_data_i);
            align_pkg::DOUT_DATA_REG:            rd_word = align_pkg::wb_data_t'(dout_data_i);
            default:                             rd_word = '0;
        endcase
    end

    // capture the access and the read word at acceptance
    always_ff @(posedge sysclk_i) begin
        if (accept) begin
            cmd.cmd_adr <= wb_adr_i;
            cmd.cmd_we  <= wb_we_i;
            cmd.cmd_sel <= wb_sel_i;
            // unselected bytes keep the previous word
            for (int i = 0; i < $bits(align_pkg::byte_sel_t); i++) begin
                if (wb_sel_i[i]) begin
                    cmd.cmd_dat[8*i +: 8] <= wb_dat_i[8*i +: 8];
                end
            end
            wb_dat_o <= rd_word;
        end
    end

    // command is consumed downstream in the ack cycle
    assign cmd.cmd_valid = (state == align_pkg::ACK);
    assign wb_ack_o      = (state == align_pkg::ACK);

endmodule

//--- logic/reg_cmd_if.sv
`timescale 1ns/1ns

interface reg_cmd_if;
    // high only in the ack cycle of an access
    logic                 cmd_valid;
    // captured access, stable until the next acceptance
    align_pkg::reg_addr_t cmd_adr;
    logic                 cmd_we;
    align_pkg::byte_sel_t cmd_sel;
    // byte merged write data
    align_pkg::wb_data_t  cmd_dat;

    // bus port side
    modport issuer (output cmd_valid, cmd_adr, cmd_we, cmd_sel, cmd_dat);
    // control bank needs the byte selects for partial control writes
    modport bank (input cmd_valid, cmd_adr, cmd_we, cmd_sel, cmd_dat);
    // error meter only looks at full interval writes
    modport meter (input cmd_valid, cmd_adr, cmd_we, cmd_dat);
endinterface

//--- logic/align_pkg.sv
package align_pkg;

    ////////////////////
    // widths
    ////////////////////

    // wishbone side
    typedef logic [5:0]  reg_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  byte_sel_t;

    // alignment side
    typedef logic [5:0]  idelay_tap_t;
    typedef logic [23:0] interval_t;
    // one bit wider than the interval so a full window of errors fits
    typedef logic [24:0] err_count_t;
    typedef logic [31:0] cout_data_t;
    typedef logic [7:0]  dout_data_t;

    // bus state machine, single cycle ack
    typedef enum logic {IDLE, ACK} bus_state_t;

    ////////////////////
    // register map
    ////////////////////

    // cout channel
    localparam reg_addr_t COUT_CONTROL_REG         = 6'h00;
    localparam reg_addr_t COUT_IDELAY_REG          = 6'h04;
    localparam reg_addr_t COUT_BIT_ERROR_COUNT_REG = 6'h08;
    localparam reg_addr_t COUT_DATA_REG            = 6'h0C;
    // dout channel
    localparam reg_addr_t DOUT_CONTROL_REG         = 6'h10;
    localparam reg_addr_t DOUT_IDELAY_REG          = 6'h14;
    localparam reg_addr_t DOUT_BIT_ERROR_COUNT_REG = 6'h18;
    localparam reg_addr_t DOUT_DATA_REG            = 6'h1C;

    // control word bits, byte 0 holds the shared resets and phase
    localparam int CTL_ISERDES_RST   = 2;
    localparam int CTL_OSERDES_RST   = 4;
    localparam int CTL_CAPTURE_PHASE = 7;
    // byte 1 holds enable and train
    localparam int CTL_ENABLE        = 8;
    localparam int CTL_ENABLE_STATUS = 9;
    localparam int CTL_CIN_TRAIN     = 10;

    // autotrain to oserdes reset release, in cycles
    localparam int AUTOTRAIN_DELAY = 16;

endpackage
